// ==== rtl/mem_bus_pkg.sv ====
package mem_bus_pkg;

   // ----------------------------------------
   // Wishbone classic bus widths
   // ----------------------------------------

   // Data path is one 32-bit word per bus cycle
   localparam int wb_data_width = 32;

   // Byte address, so bits 1:0 select a byte inside the word
   localparam int wb_addr_width = 32;

   // One select bit per byte lane
   localparam int wb_sel_width = wb_data_width / 8;

   // ----------------------------------------
   // Address map
   // ----------------------------------------

   // Set means the register block, clear means the external RAM
   localparam int reg_space_bit = 20;

   // Register offsets are word offsets, taken from address bits 3:2
   localparam logic [1:0] reg_timing_offset = 2'd0;
   localparam logic [1:0] reg_count_offset = 2'd1;

endpackage

// ==== rtl/sram_pkg.sv ====
package sram_pkg;

   // ----------------------------------------
   // Static RAM pins
   // ----------------------------------------

   // The RAM is half a bus word wide, so every word takes two RAM cycles
   localparam int sram_data_width = 16;

   // ----------------------------------------
   // Half-word cycle timing
   // ----------------------------------------

   // Width of the cycle count field
   localparam int half_cycles_width = 4;

   // Fewer than three cycles leaves no room for both setup and hold
   // around the write strobe
   localparam logic [half_cycles_width-1:0] half_cycles_min = 4'd3;

   // Largest count that fits in the field
   localparam logic [half_cycles_width-1:0] half_cycles_max = 4'd15;

   // Safe default for a 10ns part with a fast system clock
   localparam logic [half_cycles_width-1:0] half_cycles_reset = 4'd4;

   // Timing settings handed from the register block to the controller
   typedef struct packed {
      logic [half_cycles_width-1:0] half_cycles;
   } sram_timing_t;

endpackage

// ==== rtl/wb_if.sv ====
interface wb_if;

   import mem_bus_pkg::*;

   // Cycle framing and direction
   logic cyc;
   logic stb;
   logic we;

   // Request payload, held steady by the master until ack
   logic [wb_addr_width-1:0] adr;
   logic [wb_data_width-1:0] dat_w;
   logic [wb_sel_width-1:0] sel;

   // Response, valid only in the single ack cycle
   logic [wb_data_width-1:0] dat_r;
   logic ack;

   // Master side drives the request and samples the response
   modport master (
      output cyc, stb, we, adr, dat_w, sel,
      input dat_r, ack
   );

   // Slave side samples the request and drives the response
   modport slave (
      input cyc, stb, we, adr, dat_w, sel,
      output dat_r, ack
   );

endinterface

// ==== rtl/wb_decoder.sv ====
module wb_decoder (
   wb_if.slave host,
   wb_if.master mem_bus,
   wb_if.master reg_bus
);

   import mem_bus_pkg::*;

   // High when the current cycle targets the register block
   logic reg_sel;

   // ----------------------------------------
   // Address decode
   // ----------------------------------------

   // The master holds adr until ack, so the select is stable for the
   // whole cycle and the response mux below cannot switch mid-access
   assign reg_sel = host.adr[reg_space_bit];

   // ----------------------------------------
   // Request fan-out
   // ----------------------------------------

   // Only the addressed slave sees cyc and stb
   assign mem_bus.cyc = host.cyc && !reg_sel;
   assign mem_bus.stb = host.stb && !reg_sel;
   assign reg_bus.cyc = host.cyc && reg_sel;
   assign reg_bus.stb = host.stb && reg_sel;

   // Payload goes to both slaves unchanged
   assign mem_bus.we = host.we;
   assign mem_bus.adr = host.adr;
   assign mem_bus.dat_w = host.dat_w;
   assign mem_bus.sel = host.sel;

   assign reg_bus.we = host.we;
   assign reg_bus.adr = host.adr;
   assign reg_bus.dat_w = host.dat_w;
   assign reg_bus.sel = host.sel;

   // ----------------------------------------
   // Response return
   // ----------------------------------------

   // The other slave never acks since it never saw stb, but muxing keeps
   // its read data off the host bus
   assign host.dat_r = reg_sel ? reg_bus.dat_r : mem_bus.dat_r;
   assign host.ack = reg_sel ? reg_bus.ack : mem_bus.ack;

endmodule

// ==== rtl/mem_timing_regs.sv ====
module mem_timing_regs (
   input logic clock,
   input logic reset_b,
   wb_if.slave bus,
   input logic access_done,
   output sram_pkg::sram_timing_t timing
);

   import mem_bus_pkg::*;
   import sram_pkg::*;

   // Registered ack, high for one cycle per bus cycle
   logic ack_q;

   // New request seen this cycle, not yet acknowledged
   logic req;

   // Offset decode of the addressed register
   logic is_timing;
   logic is_count;

   // Write data after clamping into the legal range
   logic [half_cycles_width-1:0] half_cycles_wr;

   // Completed memory access count and read data register
   logic [wb_data_width-1:0] count_q;
   logic [wb_data_width-1:0] dat_r_q;

   // ----------------------------------------
   // Request decode
   // ----------------------------------------

   // Masking with ack_q stops a held stb from being taken twice
   assign req = bus.cyc && bus.stb && !ack_q;

   assign is_timing = (bus.adr[3:2] == reg_timing_offset);
   assign is_count = (bus.adr[3:2] == reg_count_offset);

   // Compare against the whole written word so large values clamp to max
   always_comb begin
      if (bus.dat_w < wb_data_width'(half_cycles_min))
         half_cycles_wr = half_cycles_min;
      else if (bus.dat_w > wb_data_width'(half_cycles_max))
         half_cycles_wr = half_cycles_max;
      else
         half_cycles_wr = bus.dat_w[half_cycles_width-1:0];
   end

   // ----------------------------------------
   // Control registers
   // ----------------------------------------

   always_ff @(posedge clock) begin
      if (!reset_b) begin
         ack_q <= 1'b0;
         timing.half_cycles <= half_cycles_reset;
         count_q <= '0;
      end else begin
         ack_q <= req;
         if (req && bus.we && is_timing)
            timing.half_cycles <= half_cycles_wr;
         // A counter write clears it, even if an access finishes together
         if (req && bus.we && is_count)
            count_q <= '0;
         else if (access_done)
            count_q <= count_q + 1'b1;
      end
   end

   // Read data is sampled with the request and shown in the ack cycle
   always_ff @(posedge clock) begin
      if (req) begin
         if (is_timing)
            dat_r_q <= {{(wb_data_width-half_cycles_width){1'b0}}, timing.half_cycles};
         else if (is_count)
            dat_r_q <= count_q;
         else
            dat_r_q <= '0;
      end
   end

   assign bus.ack = ack_q;
   assign bus.dat_r = dat_r_q;

endmodule

// ==== rtl/sram_controller.sv ====
module sram_controller #(
   parameter int sram_addr_width = 18
) (
   input logic clock,
   input logic reset_b,
   input sram_pkg::sram_timing_t timing,
   wb_if.slave bus,
   output logic access_done,
   output logic [sram_addr_width-1:0] ram_addr,
   output logic ram_cs_b,
   output logic ram_oe_b,
   output logic ram_we_b,
   output logic ram_ub_b,
   output logic ram_lb_b,
   output logic [sram_pkg::sram_data_width-1:0] ram_data_out,
   output logic ram_data_oe,
   input logic [sram_pkg::sram_data_width-1:0] ram_data_in
);

   import mem_bus_pkg::*;
   import sram_pkg::*;

   typedef enum logic [1:0] {
      st_idle,
      st_low,
      st_high,
      st_ack
   } state_t;

   state_t state;
   state_t state_n;

   // Cycle within the current half, 0 up to H-1
   logic [half_cycles_width-1:0] cnt;
   logic [half_cycles_width-1:0] cnt_n;

   // H as it stood at the start of the access, and its final count
   logic [half_cycles_width-1:0] h_q;
   logic [half_cycles_width-1:0] last_cnt;

   // Latched request, so the bus may not be looked at after the start
   logic [wb_addr_width-1:0] adr_q;
   logic [wb_data_width-1:0] dat_w_q;
   logic [wb_sel_width-1:0] sel_q;
   logic we_q;

   // Request as seen by the next-cycle pin logic
   logic start;
   logic [wb_addr_width-1:0] adr_src;
   logic [wb_sel_width-1:0] sel_src;
   logic we_src;
   logic active_n;

   // Captured read half-words
   logic [sram_data_width-1:0] rd_lo;
   logic [sram_data_width-1:0] rd_hi;

   assign start = (state == st_idle) && bus.cyc && bus.stb;
   assign last_cnt = h_q - 1'b1;

   // ----------------------------------------
   // Next state
   // ----------------------------------------

   always_comb begin
      state_n = state;
      cnt_n = cnt;
      case (state)
         st_idle: begin
            if (start) begin
               state_n = st_low;
               cnt_n = '0;
            end
         end
         st_low: begin
            if (cnt == last_cnt) begin
               state_n = st_high;
               cnt_n = '0;
            end else begin
               cnt_n = cnt + 1'b1;
            end
         end
         st_high: begin
            if (cnt == last_cnt)
               state_n = st_ack;
            else
               cnt_n = cnt + 1'b1;
         end
         default: state_n = st_idle;
      endcase
   end

   // The pins for the first low-half cycle are set on the edge where the
   // request is latched, so take the request straight from the bus there
   assign adr_src = (state == st_idle) ? bus.adr : adr_q;
   assign sel_src = (state == st_idle) ? bus.sel : sel_q;
   assign we_src = (state == st_idle) ? bus.we : we_q;
   assign active_n = (state_n == st_low) || (state_n == st_high);

   // ----------------------------------------
   // Control state and RAM strobes
   // ----------------------------------------

   // Every strobe comes from a flop so none can glitch
   always_ff @(posedge clock) begin
      if (!reset_b) begin
         state <= st_idle;
         cnt <= '0;
         ram_cs_b <= 1'b1;
         ram_oe_b <= 1'b1;
         ram_we_b <= 1'b1;
         ram_ub_b <= 1'b1;
         ram_lb_b <= 1'b1;
         ram_data_oe <= 1'b0;
      end else begin
         state <= state_n;
         cnt <= cnt_n;
         ram_cs_b <= !active_n;
         ram_oe_b <= !(active_n && !we_src);
         ram_data_oe <= active_n && we_src;
         // Low from the second to the second-last cycle of each half,
         // which leaves one cycle of setup and one of hold
         ram_we_b <= !(active_n && we_src && (cnt_n != '0) && (cnt_n < last_cnt));
         // Low half uses byte lanes 1:0, high half lanes 3:2
         if (state_n == st_low) begin
            ram_ub_b <= !sel_src[1];
            ram_lb_b <= !sel_src[0];
         end else if (state_n == st_high) begin
            ram_ub_b <= !sel_src[3];
            ram_lb_b <= !sel_src[2];
         end else begin
            ram_ub_b <= 1'b1;
            ram_lb_b <= 1'b1;
         end
      end
   end

   // ----------------------------------------
   // Request latch, address and read capture
   // ----------------------------------------

   always_ff @(posedge clock) begin
      // A timing register write during the access changes nothing here
      if (start) begin
         adr_q <= bus.adr;
         dat_w_q <= bus.dat_w;
         sel_q <= bus.sel;
         we_q <= bus.we;
         h_q <= timing.half_cycles;
      end
      // Word address with the half-word select as the lowest bit
      ram_addr <= {adr_src[sram_addr_width:2], state_n == st_high};
      // Sample at the end of each half, after the full access time
      if (state == st_low && cnt == last_cnt && !we_q)
         rd_lo <= ram_data_in;
      if (state == st_high && cnt == last_cnt && !we_q)
         rd_hi <= ram_data_in;
   end

   assign ram_data_out = (state == st_high) ? dat_w_q[wb_data_width-1 -: sram_data_width]
                                            : dat_w_q[sram_data_width-1:0];

   // Ack and the counter pulse share the single ack state
   assign bus.ack = (state == st_ack);
   assign bus.dat_r = {rd_hi, rd_lo};
   assign access_done = (state == st_ack);

endmodule

// ==== rtl/mem_subsystem_top.sv ====
module mem_subsystem_top #(
   parameter int sram_addr_width = 18
) (
   input logic clock,
   input logic reset_b,
   input logic wb_cyc,
   input logic wb_stb,
   input logic wb_we,
   input logic [mem_bus_pkg::wb_addr_width-1:0] wb_adr,
   input logic [mem_bus_pkg::wb_data_width-1:0] wb_dat_w,
   input logic [mem_bus_pkg::wb_sel_width-1:0] wb_sel,
   output logic [mem_bus_pkg::wb_data_width-1:0] wb_dat_r,
   output logic wb_ack,
   output logic [sram_addr_width-1:0] ram_addr,
   output logic ram_cs_b,
   output logic ram_oe_b,
   output logic ram_we_b,
   output logic ram_ub_b,
   output logic ram_lb_b,
   output logic [sram_pkg::sram_data_width-1:0] ram_data_out,
   output logic ram_data_oe,
   input logic [sram_pkg::sram_data_width-1:0] ram_data_in
);

   // Host side bus and the two decoded slave buses
   wb_if host_bus ();
   wb_if mem_bus ();
   wb_if reg_bus ();

   // Timing settings and completion pulse between registers and controller
   sram_pkg::sram_timing_t timing;
   logic access_done;

   // ----------------------------------------
   // Plain ports onto the host bus
   // ----------------------------------------

   assign host_bus.cyc = wb_cyc;
   assign host_bus.stb = wb_stb;
   assign host_bus.we = wb_we;
   assign host_bus.adr = wb_adr;
   assign host_bus.dat_w = wb_dat_w;
   assign host_bus.sel = wb_sel;
   assign wb_dat_r = host_bus.dat_r;
   assign wb_ack = host_bus.ack;

   // ----------------------------------------
   // Decoder, registers and RAM controller
   // ----------------------------------------

   wb_decoder u_wb_decoder (
      .host (host_bus),
      .mem_bus (mem_bus),
      .reg_bus (reg_bus)
   );

   mem_timing_regs u_mem_timing_regs (
      .clock (clock),
      .reset_b (reset_b),
      .bus (reg_bus),
      .access_done (access_done),
      .timing (timing)
   );

   sram_controller #(
      .sram_addr_width (sram_addr_width)
   ) u_sram_controller (
      .clock (clock),
      .reset_b (reset_b),
      .timing (timing),
      .bus (mem_bus),
      .access_done (access_done),
      .ram_addr (ram_addr),
      .ram_cs_b (ram_cs_b),
      .ram_oe_b (ram_oe_b),
      .ram_we_b (ram_we_b),
      .ram_ub_b (ram_ub_b),
      .ram_lb_b (ram_lb_b),
      .ram_data_out (ram_data_out),
      .ram_data_oe (ram_data_oe),
      .ram_data_in (ram_data_in)
   );

endmodule

// ==== verif/sram_model.sv ====
module sram_model #(
   parameter int addr_width = 18
) (
   input logic clock,
   input logic reset_b,
   input logic [addr_width-1:0] ram_addr,
   input logic ram_cs_b,
   input logic ram_oe_b,
   input logic ram_we_b,
   input logic ram_ub_b,
   input logic ram_lb_b,
   input logic [sram_pkg::sram_data_width-1:0] ram_data_out,
   input logic ram_data_oe,
   output logic [sram_pkg::sram_data_width-1:0] ram_data_in,
   input logic [sram_pkg::half_cycles_width-1:0] pulse_cycles,
   output int violations
);

   import sram_pkg::*;

   // Storage, one half-word per RAM address
   logic [sram_data_width-1:0] mem [0:(1<<addr_width)-1];

   // Pins as they stood at the previous clock edge
   logic we_b_q = 1'b1;
   logic [addr_width-1:0] addr_q;
   logic ub_b_q;
   logic lb_b_q;

   // Length of the write pulse in progress, and the running fault count
   int pulse_len = 0;
   int bad_count = 0;

   assign violations = bad_count;

   // Asynchronous read, only while chip and output enables are both low
   assign ram_data_in = (!ram_cs_b && !ram_oe_b) ? mem[ram_addr] : '0;

   // Each byte lane is written only while its own strobe is low
   always @(posedge clock) begin
      if (reset_b && !ram_cs_b && !ram_we_b) begin
         if (!ram_ub_b)
            mem[ram_addr][15:8] <= ram_data_out[15:8];
         if (!ram_lb_b)
            mem[ram_addr][7:0] <= ram_data_out[7:0];
      end
   end

   // ----------------------------------------
   // Write strobe timing checks
   // ----------------------------------------

   always @(posedge clock) begin
      if (!reset_b) begin
         pulse_len = 0;
         we_b_q = 1'b1;
      end else begin
         // The RAM output enable and the controller data drive must never overlap
         if (!ram_oe_b && ram_data_oe) begin
            $display("[ERROR] %0t ram_oe_b expected 1 actual %b while ram_data_oe is high",
                     $time, ram_oe_b);
            bad_count++;
         end
         if (!ram_we_b) begin
            // Nothing that the strobe qualifies may move while it stays low
            if (!we_b_q && ram_addr != addr_q) begin
               $display("[ERROR] %0t ram_addr expected %h actual %h", $time, addr_q, ram_addr);
               bad_count++;
            end
            if (!we_b_q && (ram_ub_b != ub_b_q || ram_lb_b != lb_b_q)) begin
               $display("[ERROR] %0t ram_ub_b,ram_lb_b expected %b%b actual %b%b",
                        $time, ub_b_q, lb_b_q, ram_ub_b, ram_lb_b);
               bad_count++;
            end
            if (ram_cs_b || !ram_data_oe) begin
               $display("[ERROR] %0t write strobe low without chip select or driven data",
                        $time);
               bad_count++;
            end
            pulse_len++;
         end else if (!we_b_q) begin
            // One cycle of setup and one of hold inside each half
            if (pulse_len != int'(pulse_cycles) - 2) begin
               $display("[ERROR] %0t ram_we_b pulse cycles expected %0d actual %0d",
                        $time, int'(pulse_cycles) - 2, pulse_len);
               bad_count++;
            end
            pulse_len = 0;
         end
         we_b_q = ram_we_b;
         addr_q = ram_addr;
         ub_b_q = ram_ub_b;
         lb_b_q = ram_lb_b;
      end
   end

endmodule

// ==== verif/tb_mem_subsystem.sv ====
module tb_mem_subsystem;

   import mem_bus_pkg::*;
   import sram_pkg::*;

   localparam int sram_addr_width = 18;
   localparam int window_words = 64;
   localparam int random_ops = 400;
   // Each random step may take two bus cycles, each at most two slow halves plus ack and gap
   localparam int bus_ops = 3 * window_words + 2 * random_ops + 4;
   localparam int watchdog_limit = bus_ops * (2 * 15 + 3) * 4 + 1000;
   localparam logic [31:0] mem_base = 32'h0000_4000;
   localparam logic [31:0] reg_base = 32'h1 << reg_space_bit;

   logic clock = 1'b0;
   logic reset_b;
   logic wb_cyc;
   logic wb_stb;
   logic wb_we;
   logic [wb_addr_width-1:0] wb_adr;
   logic [wb_data_width-1:0] wb_dat_w;
   logic [wb_sel_width-1:0] wb_sel;
   logic [wb_data_width-1:0] wb_dat_r;
   logic wb_ack;
   logic [sram_addr_width-1:0] ram_addr;
   logic ram_cs_b;
   logic ram_oe_b;
   logic ram_we_b;
   logic ram_ub_b;
   logic ram_lb_b;
   logic [sram_data_width-1:0] ram_data_out;
   logic ram_data_oe;
   logic [sram_data_width-1:0] ram_data_in;
   int violations;

   // Reference model: word contents, current H and memory access count
   logic [31:0] ref_mem [int];
   logic [half_cycles_width-1:0] model_h;
   int model_count;
   int error_count;
   logic [31:0] lcg_state = 32'h08d7_700d;

   always #2 clock = ~clock;

   mem_subsystem_top #(.sram_addr_width(sram_addr_width)) u_mem_subsystem_top (.*);

   sram_model #(.addr_width(sram_addr_width)) u_sram_model (.pulse_cycles(model_h), .*);

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Written cycle counts land on the nearest end of the 3 to 15 range
   function automatic logic [half_cycles_width-1:0] clamp_half_cycles(input logic [31:0] value);
      if (value < 32'd3)
         return 4'd3;
      if (value > 32'd15)
         return 4'd15;
      return value[half_cycles_width-1:0];
   endfunction

   // ----------------------------------------
   // Bus master
   // ----------------------------------------

   // One classic cycle, with the ack latency checked against the timing rules
   task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel, output logic [31:0] rdata);
      int cycles;
      int expect_latency;
      cycles = 0;
      expect_latency = adr[reg_space_bit] ? 1 : 2 * int'(model_h) + 1;
      @(posedge clock);
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wb_we <= we;
      wb_adr <= adr;
      wb_dat_w <= dat;
      wb_sel <= sel;
      do begin
         @(posedge clock);
         cycles++;
         // Register cycles must leave the RAM deselected
         if (adr[reg_space_bit] && ram_cs_b != 1'b1) begin
            $display("[ERROR] %0t ram_cs_b expected 1 actual %b", $time, ram_cs_b);
            error_count++;
         end
      end while (!wb_ack && cycles < 64);
      if (!wb_ack) begin
         $display("[ERROR] no acknowledge within 64 cycles for address %h at %0t", adr, $time);
         error_count++;
      end else if (cycles - 1 != expect_latency) begin
         $display("[ERROR] %0t wb_ack latency expected %0d actual %0d",
                  $time, expect_latency, cycles - 1);
         error_count++;
      end
      rdata = wb_dat_r;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we <= 1'b0;
   endtask

   task automatic write_word(input int idx, input logic [31:0] dat, input logic [3:0] sel);
      logic [31:0] rdata;
      logic [31:0] word;
      word = ref_mem.exists(idx) ? ref_mem[idx] : 32'h0;
      for (int b = 0; b < 4; b++) begin
         if (sel[b])
            word[8*b +: 8] = dat[8*b +: 8];
      end
      bus_access(1'b1, mem_base + 32'(idx * 4), dat, sel, rdata);
      ref_mem[idx] = word;
      model_count++;
   endtask

   task automatic read_word(input int idx);
      logic [31:0] rdata;
      bus_access(1'b0, mem_base + 32'(idx * 4), 32'h0, 4'hf, rdata);
      model_count++;
      if (rdata != ref_mem[idx]) begin
         $display("[ERROR] %0t wb_dat_r expected %h actual %h", $time, ref_mem[idx], rdata);
         error_count++;
      end
   endtask

   task automatic write_register(input logic [1:0] offset, input logic [31:0] value);
      logic [31:0] rdata;
      bus_access(1'b1, reg_base | {28'd0, offset, 2'b00}, value, 4'hf, rdata);
   endtask

   task automatic check_register(input logic [1:0] offset, input logic [31:0] expected);
      logic [31:0] rdata;
      bus_access(1'b0, reg_base | {28'd0, offset, 2'b00}, 32'h0, 4'hf, rdata);
      if (rdata != expected) begin
         $display("[ERROR] %0t wb_dat_r expected %h actual %h", $time, expected, rdata);
         error_count++;
      end
   endtask

   // ----------------------------------------
   // Stimulus
   // ----------------------------------------

   initial begin
      logic [31:0] r;
      logic [31:0] value;
      int idx;
      int op;
      reset_b = 1'b0;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      wb_adr = '0;
      wb_dat_w = '0;
      wb_sel = '0;
      model_h = half_cycles_reset;
      model_count = 0;
      error_count = 0;
      repeat (5) @(posedge clock);
      reset_b <= 1'b1;
      check_register(reg_timing_offset, 32'(model_h));
      // Fill the whole window with full words so later partial writes have a base
      for (idx = 0; idx < window_words; idx++)
         write_word(idx, next_random(), 4'hf);
      for (idx = 0; idx < window_words; idx++)
         read_word(idx);
      check_register(reg_count_offset, 32'(model_count));
      for (int n = 0; n < random_ops; n++) begin
         r = next_random();
         op = int'(r[31:28]);
         idx = int'(next_random() >> 26);
         if (op < 6) begin
            write_word(idx, next_random(), r[19:16]);
         end else if (op < 11) begin
            read_word(idx);
         end else if (op < 13) begin
            // Half the values are small so both clamp limits and the legal band get hit
            value = next_random();
            if (value[31])
               value = value & 32'h1f;
            write_register(reg_timing_offset, value);
            model_h = clamp_half_cycles(value);
            check_register(reg_timing_offset, 32'(model_h));
         end else if (op < 15) begin
            check_register(reg_count_offset, 32'(model_count));
         end else begin
            write_register(reg_count_offset, next_random());
            model_count = 0;
            check_register(reg_count_offset, 32'h0);
         end
      end
      // Read back the whole window so every partial write gets compared
      for (idx = 0; idx < window_words; idx++)
         read_word(idx);
      check_register(reg_count_offset, 32'(model_count));
      $display("Checks complete: %0d bus errors, %0d strobe violations", error_count, violations);
      if (error_count == 0 && violations == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   // Stops a hung bus from running forever
   initial begin
      #(watchdog_limit);
      $display("[ERROR] watchdog expired after %0d time units, the bus stopped responding",
               watchdog_limit);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// ==== list.f ====
rtl/mem_bus_pkg.sv
rtl/sram_pkg.sv
rtl/wb_if.sv
rtl/wb_decoder.sv
rtl/mem_timing_regs.sv
rtl/sram_controller.sv
rtl/mem_subsystem_top.sv
verif/sram_model.sv
verif/tb_mem_subsystem.sv

// ==== Makefile ====
# Tool, flags, top module and file list
VERILATOR  ?= verilator
LINT_FLAGS  = --lint-only --timing
SIM_FLAGS   = --binary --timing -Wno-fatal
TOP         = tb_mem_subsystem
RTL_TOP     = mem_subsystem_top
FILELIST    = list.f
BUILD_DIR   = obj_dir
LOG         = sim.log
PASS_MSG    = Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

# Lint the design alone, then the design with the testbench
lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# Build, run, and decide the result from the log
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Pass message missing from $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
